// ==== design/color_pkg.sv ====
/*
  colour generation package
  setup word layout, colour type and fixed-point widths shared by the pipeline
*/
package color_pkg;

  // one channel of triangle setup as three IEEE single floats
  typedef struct packed {
    logic [31:0] sp;
    logic [31:0] idx;
    logic [31:0] idy;
  } cmp_t;

  typedef logic [7:0] color_t;

  // signed 16.16 pixel offset from the triangle origin
  localparam int OFS_W = 32;

  // start value in unsigned 8.10
  localparam int SP_W    = 18;
  localparam int SP_FRAC = 10;

  // per-pixel gradient in signed 16.10
  localparam int GRAD_W    = 26;
  localparam int GRAD_FRAC = 10;

  // offset times gradient with 26 fraction bits
  localparam int PROD_W = OFS_W + GRAD_W;

  // 8.10 colour plus overflow and sign bits
  localparam int ACC_W = 20;

endpackage

// ==== design/pix_if.sv ====
/*
  pixel bus from the offset stage to the channel pipelines
  carries the strobe, fixed-point offsets and pixel coordinates
*/
`timescale 1ns/10ps

interface pix_if #(
  parameter int COORD_W = 12
);
  import color_pkg::*;

  logic                    valid;
  logic signed [OFS_W-1:0] dx_fx;
  logic signed [OFS_W-1:0] dy_fx;
  logic [COORD_W-1:0]      pix_x;
  logic [COORD_W-1:0]      pix_y;

  modport src (output valid, dx_fx, dy_fx, pix_x, pix_y);
  modport dst (input valid, dx_fx, dy_fx, pix_x, pix_y);

endinterface

// ==== design/flt_to_fx.sv ====
/*
  float to fixed-point converter
  truncates toward zero and saturates out-of-range magnitudes
*/
`timescale 1ns/10ps

module flt_to_fx #(
  parameter int OUT_W      = 26,
  parameter int FRAC_W     = 10,
  parameter bit SIGNED_OUT = 1'b1
) (
  input  logic [31:0]      flt_i,
  output logic [OUT_W-1:0] fx_o
);

  // magnitude bits available below the sign
  localparam int MAG_W = SIGNED_OUT ? OUT_W - 1 : OUT_W;

  logic              sgn;
  logic [7:0]        expo;
  logic [23:0]       man;
  int                sh;
  int                top;
  logic [MAG_W+23:0] wide;
  logic [MAG_W-1:0]  mag;
  logic [OUT_W-1:0]  mag_ext;

  assign sgn  = flt_i[31];
  assign expo = flt_i[30:23];
  assign man  = {1'b1, flt_i[22:0]};

  // binary point sits 23 bits into the mantissa, so scale by 2^(exp-127-23+FRAC)
  assign sh  = int'(expo) - 150 + FRAC_W;
  // position of the hidden bit after scaling
  assign top = sh + 23;

  always_comb begin
    wide = {{MAG_W{1'b0}}, man};
    if (sh >= 0) begin
      wide = wide << sh;
    end else begin
      wide = wide >> (-sh);
    end
  end

  assign mag     = wide[MAG_W-1:0];
  assign mag_ext = OUT_W'(mag);

  always_comb begin
    if (expo == 8'd0) begin
      // zero and denormals
      fx_o = '0;
    end else if (sgn && !SIGNED_OUT) begin
      fx_o = '0;
    end else if (top >= MAG_W) begin
      // magnitude too large including inf and nan
      if (!SIGNED_OUT) begin
        fx_o = '1;
      end else if (sgn) begin
        fx_o = {1'b1, {(OUT_W-1){1'b0}}};
      end else begin
        fx_o = {1'b0, {(OUT_W-1){1'b1}}};
      end
    end else if (sgn) begin
      fx_o = -mag_ext;
    end else begin
      fx_o = mag_ext;
    end
  end

endmodule

// ==== design/pixel_offset.sv ====
/*
  pixel offset stage
  registers a pixel and forms its 16.16 centre offsets from the origin
*/
`timescale 1ns/10ps

module pixel_offset #(
  parameter int COORD_W = 12
) (
  input  logic                               clk,
  input  logic                               rstn,
  input  logic                               pix_valid_i,
  input  logic [COORD_W-1:0]                 pix_x_i,
  input  logic [COORD_W-1:0]                 pix_y_i,
  input  logic signed [color_pkg::OFS_W-1:0] org_x_i,
  input  logic signed [color_pkg::OFS_W-1:0] org_y_i,
  pix_if.src                                 pix_o
);
  import color_pkg::*;

  logic signed [OFS_W-1:0] cx;
  logic signed [OFS_W-1:0] cy;

  // pixel centre in 16.16 lies half a pixel past the integer coordinate
  assign cx = OFS_W'({pix_x_i, 16'h8000});
  assign cy = OFS_W'({pix_y_i, 16'h8000});

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pix_o.valid <= 1'b0;
      pix_o.dx_fx <= '0;
      pix_o.dy_fx <= '0;
      pix_o.pix_x <= '0;
      pix_o.pix_y <= '0;
    end else begin
      pix_o.valid <= pix_valid_i;
      // data only moves with a pixel
      if (pix_valid_i) begin
        pix_o.dx_fx <= cx - org_x_i;
        pix_o.dy_fx <= cy - org_y_i;
        pix_o.pix_x <= pix_x_i;
        pix_o.pix_y <= pix_y_i;
      end
    end
  end

endmodule

// ==== design/color_interp.sv ====
/*
  single colour channel
  start + dx*gradx + dy*grady over three stages, clamped to 8 bits
*/
`timescale 1ns/10ps

module color_interp #(
  parameter int COORD_W     = 12,
  parameter bit TRACK_COORD = 1'b1
) (
  input  logic                clk,
  input  logic                rstn,
  pix_if.dst                  pix_i,
  input  color_pkg::cmp_t     cmp_i,
  output logic                valid_o,
  output color_pkg::color_t   color_o,
  output logic [COORD_W-1:0]  pix_x_o,
  output logic [COORD_W-1:0]  pix_y_o
);
  import color_pkg::*;

  logic [SP_W-1:0]          sp_fx;
  logic signed [GRAD_W-1:0] idx_fx;
  logic signed [GRAD_W-1:0] idy_fx;
  logic signed [PROD_W-1:0] ix;
  logic signed [PROD_W-1:0] iy;
  logic signed [PROD_W-1:0] ixy;
  logic [ACC_W-1:0]         acc;
  logic [2:0]               v_q;

  flt_to_fx #(.OUT_W(SP_W), .FRAC_W(SP_FRAC), .SIGNED_OUT(1'b0)) u_sp (
    .flt_i (cmp_i.sp),
    .fx_o  (sp_fx)
  );

  flt_to_fx #(.OUT_W(GRAD_W), .FRAC_W(GRAD_FRAC), .SIGNED_OUT(1'b1)) u_idx (
    .flt_i (cmp_i.idx),
    .fx_o  (idx_fx)
  );

  flt_to_fx #(.OUT_W(GRAD_W), .FRAC_W(GRAD_FRAC), .SIGNED_OUT(1'b1)) u_idy (
    .flt_i (cmp_i.idy),
    .fx_o  (idy_fx)
  );

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      v_q <= '0;
      ix  <= '0;
      iy  <= '0;
      ixy <= '0;
      acc <= '0;
    end else begin
      v_q <= {v_q[1:0], pix_i.valid};
      ix  <= pix_i.dx_fx * idx_fx;
      iy  <= pix_i.dy_fx * idy_fx;
      ixy <= ix + iy;
      // drop the 16 offset fraction bits to line up with the 8.10 start
      acc <= ixy[16 +: ACC_W] + ACC_W'(sp_fx);
    end
  end

  assign valid_o = v_q[2];

  // top bit is sign, next one is 256 or more
  always_comb begin
    if (acc[ACC_W-1]) begin
      color_o = '0;
    end else if (acc[ACC_W-2]) begin
      color_o = '1;
    end else begin
      color_o = acc[SP_FRAC +: $bits(color_t)];
    end
  end

  if (TRACK_COORD) begin : g_coord
    logic [COORD_W-1:0] x_q [3];
    logic [COORD_W-1:0] y_q [3];

    always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
        for (int i = 0; i < 3; i++) begin
          x_q[i] <= '0;
          y_q[i] <= '0;
        end
      end else begin
        x_q[0] <= pix_i.pix_x;
        y_q[0] <= pix_i.pix_y;
        for (int i = 1; i < 3; i++) begin
          x_q[i] <= x_q[i-1];
          y_q[i] <= y_q[i-1];
        end
      end
    end

    assign pix_x_o = x_q[2];
    assign pix_y_o = y_q[2];
  end else begin : g_no_coord
    assign pix_x_o = '0;
    assign pix_y_o = '0;
  end

endmodule

// ==== design/color_gen_top.sv ====
/*
  colour generator top level
  offset stage feeding red, green and blue interpolation pipelines
*/
`timescale 1ns/10ps

module color_gen_top #(
  parameter int COORD_W = 12
) (
  input  logic                                   clk,
  input  logic                                   rstn,
  input  logic [$bits(color_pkg::cmp_t)-1:0]     red_cmp_i,
  input  logic [$bits(color_pkg::cmp_t)-1:0]     grn_cmp_i,
  input  logic [$bits(color_pkg::cmp_t)-1:0]     blu_cmp_i,
  input  logic signed [color_pkg::OFS_W-1:0]     org_x_i,
  input  logic signed [color_pkg::OFS_W-1:0]     org_y_i,
  input  logic                                   pix_valid_i,
  input  logic [COORD_W-1:0]                     pix_x_i,
  input  logic [COORD_W-1:0]                     pix_y_i,
  output logic                                   pix_valid_o,
  output logic [COORD_W-1:0]                     pix_x_o,
  output logic [COORD_W-1:0]                     pix_y_o,
  output color_pkg::color_t                      red_o,
  output color_pkg::color_t                      grn_o,
  output color_pkg::color_t                      blu_o
);
  import color_pkg::*;

  pix_if #(.COORD_W(COORD_W)) pix ();

  pixel_offset #(.COORD_W(COORD_W)) u_offset (
    .clk         (clk),
    .rstn        (rstn),
    .pix_valid_i (pix_valid_i),
    .pix_x_i     (pix_x_i),
    .pix_y_i     (pix_y_i),
    .org_x_i     (org_x_i),
    .org_y_i     (org_y_i),
    .pix_o       (pix.src)
  );

  // red carries the coordinates and the output strobe
  color_interp #(.COORD_W(COORD_W), .TRACK_COORD(1'b1)) u_red (
    .clk     (clk),
    .rstn    (rstn),
    .pix_i   (pix.dst),
    .cmp_i   (cmp_t'(red_cmp_i)),
    .valid_o (pix_valid_o),
    .color_o (red_o),
    .pix_x_o (pix_x_o),
    .pix_y_o (pix_y_o)
  );

  color_interp #(.COORD_W(COORD_W), .TRACK_COORD(1'b0)) u_grn (
    .clk     (clk),
    .rstn    (rstn),
    .pix_i   (pix.dst),
    .cmp_i   (cmp_t'(grn_cmp_i)),
    .valid_o (),
    .color_o (grn_o),
    .pix_x_o (),
    .pix_y_o ()
  );

  color_interp #(.COORD_W(COORD_W), .TRACK_COORD(1'b0)) u_blu (
    .clk     (clk),
    .rstn    (rstn),
    .pix_i   (pix.dst),
    .cmp_i   (cmp_t'(blu_cmp_i)),
    .valid_o (),
    .color_o (blu_o),
    .pix_x_o (),
    .pix_y_o ()
  );

endmodule

// ==== test/color_interp_asserts.sv ====
/*
  assertions on one colour channel pipeline
*/
`timescale 1ns/10ps

module color_interp_asserts (
  input logic                     clk,
  input logic                     rstn,
  input logic signed [31:0]       dx_fx,
  input logic signed [31:0]       dy_fx,
  input logic signed [25:0]       idx_fx,
  input logic signed [25:0]       idy_fx,
  input logic signed [57:0]       ix,
  input logic signed [57:0]       iy,
  input logic signed [57:0]       ixy,
  input logic [19:0]              acc,
  input logic [17:0]              sp_fx,
  input color_pkg::cmp_t          cmp_i,
  input color_pkg::color_t        color_o
);
  int fail_cnt = 0;

  a_prod: assert property (@(posedge clk) disable iff (!rstn)
    ix == $past(dx_fx) * $past(idx_fx) && iy == $past(dy_fx) * $past(idy_fx))
    else begin $error("product mismatch"); fail_cnt++; end

  a_sum: assert property (@(posedge clk) disable iff (!rstn) ixy == $past(ix) + $past(iy))
    else begin $error("sum mismatch"); fail_cnt++; end

  // sign gives 0, bit 18 gives 255, otherwise the integer part
  a_neg: assert property (@(posedge clk) acc[19] |-> color_o == 8'd0)
    else begin $error("negative clamp"); fail_cnt++; end
  a_big: assert property (@(posedge clk) !acc[19] && acc[18] |-> color_o == 8'd255)
    else begin $error("overflow clamp"); fail_cnt++; end
  a_mid: assert property (@(posedge clk) acc[19:18] == 2'b00 |-> color_o == acc[17:10])
    else begin $error("in-range colour"); fail_cnt++; end

  a_zero: assert property (@(posedge clk) cmp_i.sp[30:23] == 8'd0 |-> sp_fx == '0)
    else begin $error("zero float not zero"); fail_cnt++; end

endmodule

// ==== test/color_gen_checker.sv ====
/*
  output checker, compares each output pixel with the next expected entry
*/
`timescale 1ns/10ps

module color_gen_checker #(
  parameter int COORD_W = 12
) (
  input logic               clk,
  input logic               rstn,
  input logic               pix_valid_i,
  input logic               pix_valid_o,
  input logic [COORD_W-1:0] pix_x_o,
  input logic [COORD_W-1:0] pix_y_o,
  input logic [7:0]         red_o,
  input logic [7:0]         grn_o,
  input logic [7:0]         blu_o
);
  string                      name_q[$];
  logic [2*COORD_W+23:0]      exp_q[$];
  int                         in_q[$];
  int                         cycle = 0;
  int                         pass_cnt = 0;
  int                         fail_cnt = 0;
  int                         err_cnt = 0;
  logic [2*COORD_W+23:0]      ev;
  logic [2*COORD_W+23:0]      got;
  string                      nm;
  int                         t_in;

  task automatic expect_pixel(input string n, input logic [COORD_W-1:0] x,
                              input logic [COORD_W-1:0] y, input logic [23:0] rgb);
    name_q.push_back(n);
    exp_q.push_back({x, y, rgb});
  endtask

  function automatic int pending();
    return exp_q.size();
  endfunction

  always @(posedge clk) begin
    cycle = cycle + 1;
    got = {pix_x_o, pix_y_o, red_o, grn_o, blu_o};
    if (!rstn) begin
      if (pix_valid_o) begin
        err_cnt++;
        $display("output strobe high during reset");
      end
    end else begin
      if (pix_valid_i) in_q.push_back(cycle);
      if (pix_valid_o && exp_q.size() == 0) begin
        err_cnt++;
        $display("output pixel (%0d,%0d) with no test pending", pix_x_o, pix_y_o);
      end else if (pix_valid_o) begin
        ev = exp_q.pop_front();
        nm = name_q.pop_front();
        t_in = (in_q.size() > 0) ? in_q.pop_front() : -100;
        if (cycle - t_in != 4) begin
          err_cnt++;
          $display("%s came out %0d cycles after its input strobe, not 4", nm, cycle - t_in);
        end
        if (got === ev) begin
          pass_cnt++;
          $display("ok     %s", nm);
        end else begin
          fail_cnt++;
          $display("FAILED %s: expected x=%0d y=%0d rgb=%0d,%0d,%0d got x=%0d y=%0d rgb=%0d,%0d,%0d",
                   nm, ev[2*COORD_W+23 -: COORD_W], ev[COORD_W+23 -: COORD_W],
                   ev[23:16], ev[15:8], ev[7:0], pix_x_o, pix_y_o, red_o, grn_o, blu_o);
        end
      end
    end
  end

endmodule

// ==== test/color_gen_tb.sv ====
/*
  colour generator testbench
  applies a table of pixels with known colours and summarises the results
*/
`timescale 1ns/10ps

module color_gen_tb;
  localparam int N     = 11;
  localparam int LIMIT = N * 8 + 50;
  // setup words {start, gradx, grady}
  localparam logic [95:0] FLAT_R = {32'h42C80000, 32'h0, 32'h0};
  localparam logic [95:0] FLAT_G = {32'h42C90000, 32'h0, 32'h0};
  localparam logic [95:0] FLAT_B = {32'h41200000, 32'h80000000, 32'h0};
  localparam logic [95:0] LIN_R  = {32'h0, 32'h3F800000, 32'h0};
  localparam logic [95:0] LIN_G  = {32'h0, 32'h0, 32'h3F000000};
  localparam logic [95:0] LIN_B  = {32'h41200000, 32'h3F800000, 32'h3F800000};
  localparam logic [95:0] OVF_R  = {32'h43480000, 32'h3F800000, 32'h0};
  localparam logic [95:0] OVF_G  = {32'h437F0000, 32'h3F000000, 32'h0};
  localparam logic [95:0] OVF_B  = {32'h7F000000, 32'h0, 32'h0};
  localparam logic [95:0] UNF_R  = {32'h41200000, 32'hBF800000, 32'h0};
  localparam logic [95:0] UNF_G  = {32'hC0A00000, 32'h0, 32'h0};
  localparam logic [95:0] UNF_B  = {32'h42C80000, 32'h0, 32'hC0000000};

  logic clk = 1'b0;
  logic rstn, pix_valid_i, pix_valid_o;
  logic [95:0] red_cmp_i, grn_cmp_i, blu_cmp_i;
  logic signed [31:0] org_x_i, org_y_i;
  logic [11:0] pix_x_i, pix_y_i, pix_x_o, pix_y_o;
  logic [7:0] red_o, grn_o, blu_o;

  string t_name[N];
  logic [95:0] t_r[N], t_g[N], t_b[N];
  logic [31:0] t_ox[N], t_oy[N];
  logic [11:0] t_x[N], t_y[N];
  logic [23:0] t_exp[N];
  bit t_b2b[N];
  int n = 0;
  int seed = 43594;
  int cycles = 0;
  int gap, bad;

  always #5 clk = ~clk;

  color_gen_top #(.COORD_W(12)) dut (.*);

  color_gen_checker #(.COORD_W(12)) chk (.*);

  bind color_interp color_interp_asserts u_asrt (
    .clk(clk), .rstn(rstn), .dx_fx(pix_i.dx_fx), .dy_fx(pix_i.dy_fx), .idx_fx(idx_fx),
    .idy_fx(idy_fx), .ix(ix), .iy(iy), .ixy(ixy), .acc(acc), .sp_fx(sp_fx),
    .cmp_i(cmp_i), .color_o(color_o)
  );

  task automatic add_test(input string nm, input logic [95:0] r, g, b,
                          input logic [31:0] ox, oy, input int x, y,
                          input logic [23:0] rgb, input bit b2b);
    t_name[n] = nm;
    t_r[n] = r;
    t_g[n] = g;
    t_b[n] = b;
    t_ox[n] = ox;
    t_oy[n] = oy;
    t_x[n] = 12'(x);
    t_y[n] = 12'(y);
    t_exp[n] = rgb;
    t_b2b[n] = b2b;
    n++;
  endtask

  // idle until every pixel in flight has been checked
  task automatic drain();
    @(posedge clk);
    pix_valid_i <= 1'b0;
    while (chk.pending() != 0) @(negedge clk);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout after %0d cycles with %0d pixels pending", cycles, chk.pending());
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    rstn = 1'b0;
    pix_valid_i = 1'b0;
    {red_cmp_i, grn_cmp_i, blu_cmp_i} = '0;
    {org_x_i, org_y_i, pix_x_i, pix_y_i} = '0;
    add_test("flat_a", FLAT_R, FLAT_G, FLAT_B, 0, 0, 5, 7, {8'd100, 8'd100, 8'd10}, 0);
    add_test("flat_b", FLAT_R, FLAT_G, FLAT_B, 0, 0, 300, 1000, {8'd100, 8'd100, 8'd10}, 0);
    add_test("lin_a", LIN_R, LIN_G, LIN_B, 0, 0, 10, 20, {8'd10, 8'd10, 8'd41}, 0);
    add_test("lin_b", LIN_R, LIN_G, LIN_B, 0, 0, 100, 50, {8'd100, 8'd25, 8'd161}, 0);
    add_test("lin_org", LIN_R, LIN_G, LIN_B, 32'h24000, 32'h18000, 10, 20,
             {8'd8, 8'd9, 8'd37}, 0);
    add_test("ovf", OVF_R, OVF_G, OVF_B, 0, 0, 100, 0, {8'd255, 8'd255, 8'd255}, 0);
    add_test("unf", UNF_R, UNF_G, UNF_B, 0, 0, 50, 0, {8'd0, 8'd0, 8'd99}, 0);
    add_test("b2b_0", LIN_R, LIN_G, LIN_B, 0, 0, 1, 2, {8'd1, 8'd1, 8'd14}, 0);
    add_test("b2b_1", LIN_R, LIN_G, LIN_B, 0, 0, 2, 3, {8'd2, 8'd1, 8'd16}, 1);
    add_test("b2b_2", LIN_R, LIN_G, LIN_B, 0, 0, 3, 4, {8'd3, 8'd2, 8'd18}, 1);
    add_test("b2b_3", LIN_R, LIN_G, LIN_B, 0, 0, 4, 5, {8'd4, 8'd2, 8'd20}, 1);
    repeat (5) @(posedge clk);
    rstn <= 1'b1;
    for (int i = 0; i < N; i++) begin
      if (!t_b2b[i]) begin
        drain();
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) @(posedge clk);
      end
      @(posedge clk);
      pix_valid_i <= 1'b1;
      {red_cmp_i, grn_cmp_i, blu_cmp_i} <= {t_r[i], t_g[i], t_b[i]};
      {org_x_i, org_y_i, pix_x_i, pix_y_i} <= {t_ox[i], t_oy[i], t_x[i], t_y[i]};
      chk.expect_pixel(t_name[i], t_x[i], t_y[i], t_exp[i]);
    end
    drain();
    // a few idle cycles to catch stray output strobes
    repeat (8) @(posedge clk);
    bad = chk.fail_cnt + chk.err_cnt + dut.u_red.u_asrt.fail_cnt
        + dut.u_grn.u_asrt.fail_cnt + dut.u_blu.u_asrt.fail_cnt;
    $display("%0d passed, %0d failed, %0d other errors of %0d tests",
             chk.pass_cnt, chk.fail_cnt, bad - chk.fail_cnt, N);
    if (bad == 0 && chk.pass_cnt == N) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== color_gen.f ====
design/color_pkg.sv
design/pix_if.sv
design/flt_to_fx.sv
design/pixel_offset.sv
design/color_interp.sv
design/color_gen_top.sv
test/color_interp_asserts.sv
test/color_gen_checker.sv
test/color_gen_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
RUNFLAGS  ?= +verilator+error+limit+100
TOP       := color_gen_tb
FILELIST  := color_gen.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	@grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
